/* build.f */
+incdir+source
source/epu_pkg.sv
source/epu_irqc_if.sv
source/epu_trap_if.sv
source/epu_irqc.sv
source/epu_msr.sv
source/epu_trap_ctrl.sv
source/epu_top.sv
verif/epu_checker.sv
verif/tb_epu.sv

/* source/epu_config.svh */
/*
 Build-time constants of the exception processing unit.
 Include wherever widths, MSR addresses or the interrupt vector are needed.
 EPU_NUM_IRQ must stay at or below EPU_DW.
 */
`ifndef EPU_CONFIG_SVH
`define EPU_CONFIG_SVH

// Datapath and IRQ line count
`define EPU_DW          64
`define EPU_NUM_IRQ     32

// MSR address map
`define EPU_MSR_AW      4
`define EPU_ADDR_PSR    4'h0
`define EPU_ADDR_EPSR   4'h1
`define EPU_ADDR_EPC    4'h2
`define EPU_ADDR_IMR    4'h3
`define EPU_ADDR_IRR    4'h4

// Entry PC for every interrupt
`define EPU_IRQ_VECTOR  64'h0000_0000_8000_0100

`endif

/* source/epu_irqc.sv */
/*
 Interrupt controller. Two-flop synchronizer into the IRR, the IMR
 with same-cycle write bypass, and one combined interrupt request
 qualified by PSR.ire.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module epu_irqc (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`EPU_NUM_IRQ-1:0]  irqs,
   input  logic                     psr_ire,
   epu_irqc_if.irqc                 irqc,
   output logic                     irq_req
);

   logic [`EPU_NUM_IRQ-1:0]  sync_q;
   logic [`EPU_NUM_IRQ-1:0]  irr_q;
   logic [`EPU_DW-1:0]       imr_q;
   logic [`EPU_DW-1:0]       irq_masked;

   // External lines are asynchronous
   // Second stage is the IRR itself
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '0;
         irr_q  <= '0;
      end else begin
         sync_q <= irqs;
         irr_q  <= sync_q;
      end
   end

   // Everything masked out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         imr_q <= '1;
      end else if (irqc.imr_we) begin
         imr_q <= irqc.imr_nxt;
      end
   end

   // Mask write visible in the same cycle
   assign irqc.imr = irqc.imr_we ? irqc.imr_nxt : imr_q;

   // Upper IRR bits read as zero
   assign irqc.irr = `EPU_DW'(irr_q);

   // Pending and unmasked
   assign irq_masked = irqc.irr & ~irqc.imr;
   assign irq_req    = (|irq_masked) & psr_ire;

endmodule

`default_nettype wire

/* source/epu_irqc_if.sv */
/*
 IMR access and pending state between the MSR file and the
 interrupt controller. The MSR file drives the mask write, the
 controller returns the bypassed IMR and the IRR.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

interface epu_irqc_if;

   // Mask write from the MSR file
   logic                imr_we;
   logic [`EPU_DW-1:0]  imr_nxt;
   // Mask and pending lines back
   logic [`EPU_DW-1:0]  imr;
   logic [`EPU_DW-1:0]  irr;

   modport msr  (output imr_we, output imr_nxt, input imr, input irr);
   modport irqc (input imr_we, input imr_nxt, output imr, output irr);

endinterface

`default_nettype wire

/* source/epu_msr.sv */
/*
 Machine special register file: PSR, EPSR, EPC, plus IMR and IRR
 access through the interrupt controller. Software writes use a plain
 address port; trap entry and return update PSR, EPSR and EPC with
 priority over software. Reads are combinational.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module epu_msr (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   msr_we,
   input  epu_pkg::msr_addr_t     msr_addr,
   input  epu_pkg::msr_wdat_u     msr_wdat,
   output logic [`EPU_DW-1:0]     msr_rdat,
   output logic                   psr_ire,
   epu_irqc_if.msr                irqc,
   epu_trap_if.msr                trap
);

   import epu_pkg::*;

   psr_t                psr_q;
   psr_t                epsr_q;
   logic [`EPU_DW-1:0]  epc_q;
   psr_t                psr_wr;
   logic                trap_busy;
   logic                we_psr;
   logic                we_epsr;
   logic                we_epc;

   // Write word seen as PSR fields
   // Reserved bits never stored
   always_comb begin
      psr_wr     = '0;
      psr_wr.rm  = msr_wdat.psr.rm;
      psr_wr.ire = msr_wdat.psr.ire;
   end

   // Any trap action blocks software writes to PSR, EPSR, EPC
   assign trap_busy = trap.enter | trap.leave;

   // Address decode
   assign we_psr  = msr_we && (msr_addr == MSR_PSR);
   assign we_epsr = msr_we && (msr_addr == MSR_EPSR);
   assign we_epc  = msr_we && (msr_addr == MSR_EPC);

   // IMR lives in the interrupt controller
   // Always applies, trap or not
   assign irqc.imr_we  = msr_we && (msr_addr == MSR_IMR);
   assign irqc.imr_nxt = msr_wdat.raw;

   // PSR
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr_q <= '0;
      end else if (trap.leave) begin
         // Return restores saved status
         psr_q <= epsr_q;
      end else if (trap.enter) begin
         // Kernel mode, interrupts off
         psr_q <= '{rsvd: '0, rm: 1'b1, ire: 1'b0};
      end else if (we_psr) begin
         psr_q <= psr_wr;
      end
   end

   // EPSR
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epsr_q <= '0;
      end else if (trap.enter) begin
         epsr_q <= psr_q;
      end else if (we_epsr && !trap_busy) begin
         epsr_q <= psr_wr;
      end
   end

   // EPC
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epc_q <= '0;
      end else if (trap.enter) begin
         epc_q <= trap.epc_nxt;
      end else if (we_epc && !trap_busy) begin
         epc_q <= msr_wdat.raw;
      end
   end

   // State for the other blocks
   assign psr_ire      = psr_q.ire;
   assign trap.psr_ire = psr_q.ire;
   assign trap.epc     = epc_q;

   // Read mux
   // IMR read shows a write in flight
   always_comb begin
      case (msr_addr)
         MSR_PSR:  msr_rdat = psr_q;
         MSR_EPSR: msr_rdat = epsr_q;
         MSR_EPC:  msr_rdat = epc_q;
         MSR_IMR:  msr_rdat = irqc.imr;
         MSR_IRR:  msr_rdat = irqc.irr;
         default:  msr_rdat = '0;
      endcase
   end

endmodule

`default_nettype wire

/* source/epu_pkg.sv */
/*
 Types shared by the EPU blocks: MSR addresses, PSR layout and the
 MSR write word, which the MSR file reads either raw or as PSR fields.
 */
`default_nettype none

`include "epu_config.svh"

package epu_pkg;

   // Machine special register addresses
   typedef enum logic [`EPU_MSR_AW-1:0] {
      MSR_PSR  = `EPU_ADDR_PSR,
      MSR_EPSR = `EPU_ADDR_EPSR,
      MSR_EPC  = `EPU_ADDR_EPC,
      MSR_IMR  = `EPU_ADDR_IMR,
      MSR_IRR  = `EPU_ADDR_IRR
   } msr_addr_t;

   // Processor status word, ire in bit 0
   typedef struct packed {
      logic [`EPU_DW-3:0] rsvd;
      // Kernel mode
      logic               rm;
      // Interrupt enable
      logic               ire;
   } psr_t;

   // One write word, two views
   typedef union packed {
      logic [`EPU_DW-1:0] raw;
      psr_t               psr;
   } msr_wdat_u;

endpackage

`default_nettype wire

/* source/epu_top.sv */
/*
 Interrupt and exception-entry top level. Ties the interrupt
 controller, the MSR file and the trap controller together through
 their interfaces; plain ports to the rest of the CPU.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module epu_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`EPU_NUM_IRQ-1:0]  irqs,
   input  logic                     retire_valid,
   input  logic [`EPU_DW-1:0]       retire_pc,
   input  logic                     retire_eret,
   input  logic                     msr_we,
   input  logic [`EPU_MSR_AW-1:0]   msr_addr,
   input  logic [`EPU_DW-1:0]       msr_wdat,
   output logic [`EPU_DW-1:0]       msr_rdat,
   output logic                     irq_req,
   output logic                     redirect_valid,
   output logic [`EPU_DW-1:0]       redirect_pc
);

   import epu_pkg::*;

   logic  psr_ire;

   epu_irqc_if  u_irqc_if ();
   epu_trap_if  u_trap_if ();

   // Pending and mask state
   epu_irqc u_irqc (
      .clk     (clk),
      .arst_n  (arst_n),
      .irqs    (irqs),
      .psr_ire (psr_ire),
      .irqc    (u_irqc_if.irqc),
      .irq_req (irq_req)
   );

   // Address arrives as a plain vector
   epu_msr u_msr (
      .clk      (clk),
      .arst_n   (arst_n),
      .msr_we   (msr_we),
      .msr_addr (msr_addr_t'(msr_addr)),
      .msr_wdat (msr_wdat),
      .msr_rdat (msr_rdat),
      .psr_ire  (psr_ire),
      .irqc     (u_irqc_if.msr),
      .trap     (u_trap_if.msr)
   );

   epu_trap_ctrl u_trap_ctrl (
      .clk            (clk),
      .arst_n         (arst_n),
      .retire_valid   (retire_valid),
      .retire_pc      (retire_pc),
      .retire_eret    (retire_eret),
      .irq_req        (irq_req),
      .trap           (u_trap_if.trap),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc)
   );

endmodule

`default_nettype wire

/* source/epu_trap_ctrl.sv */
/*
 Trap controller. At each retirement picks exception return or
 interrupt entry, return first, and strobes the MSR file. The
 redirect to the front end is a registered one-cycle pulse.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module epu_trap_ctrl (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                retire_valid,
   input  logic [`EPU_DW-1:0]  retire_pc,
   input  logic                retire_eret,
   input  logic                irq_req,
   epu_trap_if.trap            trap,
   output logic                redirect_valid,
   output logic [`EPU_DW-1:0]  redirect_pc
);

   logic                do_leave;
   logic                do_enter;
   logic                redir_q;
   logic [`EPU_DW-1:0]  redir_pc_q;

   // Return wins over a pending interrupt
   assign do_leave = retire_valid & retire_eret;

   // irq_req already carries ire, checked again against the MSR state
   assign do_enter = retire_valid & ~retire_eret & irq_req & trap.psr_ire;

   assign trap.leave   = do_leave;
   assign trap.enter   = do_enter;
   // Interrupted instruction resumes at its own PC
   assign trap.epc_nxt = retire_pc;

   // One-cycle redirect pulse
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         redir_q <= 1'b0;
      end else begin
         redir_q <= do_leave | do_enter;
      end
   end

   // Target sampled at the decision
   // EPC taken before the return edge
   always_ff @(posedge clk) begin
      if (do_leave) begin
         redir_pc_q <= trap.epc;
      end else if (do_enter) begin
         redir_pc_q <= `EPU_IRQ_VECTOR;
      end
   end

   assign redirect_valid = redir_q;
   assign redirect_pc    = redir_pc_q;

endmodule

`default_nettype wire

/* source/epu_trap_if.sv */
/*
 Trap state transfer between the trap controller and the MSR file.
 Entry and return strobes go to the MSR file together with the PC
 to save; the MSR file returns interrupt enable and the current EPC.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

interface epu_trap_if;

   // Strobes from the trap controller
   logic                enter;
   logic                leave;
   // PC saved on entry
   logic [`EPU_DW-1:0]  epc_nxt;
   // State seen by the trap controller
   logic                psr_ire;
   logic [`EPU_DW-1:0]  epc;

   modport trap (output enter, output leave, output epc_nxt, input psr_ire, input epc);
   modport msr  (input enter, input leave, input epc_nxt, output psr_ire, output epc);

endinterface

`default_nettype wire

/* verif/epu_checker.sv */
/*
 Reference model and scoreboard for the EPU. Watches the top-level
 ports, models synchronizer, PSR, EPSR, EPC, IMR and the redirect
 register, and compares on every rising clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module epu_checker (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`EPU_NUM_IRQ-1:0]  irqs,
   input  logic                     retire_valid,
   input  logic [`EPU_DW-1:0]       retire_pc,
   input  logic                     retire_eret,
   input  logic                     msr_we,
   input  logic [`EPU_MSR_AW-1:0]   msr_addr,
   input  logic [`EPU_DW-1:0]       msr_wdat,
   input  logic [`EPU_DW-1:0]       msr_rdat,
   input  logic                     irq_req,
   input  logic                     redirect_valid,
   input  logic [`EPU_DW-1:0]       redirect_pc,
   output logic [31:0]              mismatches,
   output logic [31:0]              checks,
   output logic [31:0]              entries,
   output logic [31:0]              returns
);

   // Model state, PSR as ire in bit 0 and rm in bit 1
   logic [`EPU_NUM_IRQ-1:0]  sync_m;
   logic [`EPU_NUM_IRQ-1:0]  irr_m;
   logic [`EPU_DW-1:0]       psr_m;
   logic [`EPU_DW-1:0]       epsr_m;
   logic [`EPU_DW-1:0]       epc_m;
   logic [`EPU_DW-1:0]       imr_m;
   logic                     redir_v_m;
   logic [`EPU_DW-1:0]       redir_pc_m;
   // Per-cycle values
   logic [`EPU_DW-1:0]       irr_ext;
   logic [`EPU_DW-1:0]       imr_eff;
   logic [`EPU_DW-1:0]       wr_psr;
   logic [`EPU_DW-1:0]       exp_rdat;
   logic                     exp_req;
   logic                     leave;
   logic                     enter;

   initial begin
      mismatches = 0;
      checks     = 0;
      entries    = 0;
      returns    = 0;
   end

   task automatic compare(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
      if (act_v !== exp_v) begin
         mismatches = mismatches + 1;
         $display("FAILED %s: expected %h, got %h at %0t ns", name, exp_v, act_v, $time);
      end
   endtask

   // Inputs settle on the falling edge, so all ports are stable here
   always @(posedge clk) begin
      if (!arst_n) begin
         sync_m    = '0;
         irr_m     = '0;
         psr_m     = '0;
         epsr_m    = '0;
         epc_m     = '0;
         imr_m     = '1;
         redir_v_m = 1'b0;
      end else begin
         checks = checks + 1;
         irr_ext = '0;
         irr_ext[`EPU_NUM_IRQ-1:0] = irr_m;
         // Mask write counts in its own cycle
         imr_eff = (msr_we && msr_addr == `EPU_ADDR_IMR) ? msr_wdat : imr_m;
         exp_req = (|(irr_ext & ~imr_eff)) && psr_m[0];
         case (msr_addr)
            `EPU_ADDR_PSR:  exp_rdat = psr_m;
            `EPU_ADDR_EPSR: exp_rdat = epsr_m;
            `EPU_ADDR_EPC:  exp_rdat = epc_m;
            `EPU_ADDR_IMR:  exp_rdat = imr_eff;
            `EPU_ADDR_IRR:  exp_rdat = irr_ext;
            default:        exp_rdat = '0;
         endcase
         compare("irq_req", exp_req, irq_req);
         compare("msr_rdat", exp_rdat, msr_rdat);
         compare("redirect_valid", redir_v_m, redirect_valid);
         // Target only meaningful during the pulse
         if (redir_v_m)
            compare("redirect_pc", redir_pc_m, redirect_pc);

         // Return first, entry only when a request is up
         leave  = retire_valid && retire_eret;
         enter  = retire_valid && !retire_eret && exp_req;
         wr_psr = '0;
         wr_psr[1:0] = msr_wdat[1:0];
         if (leave)
            returns = returns + 1;
         if (enter)
            entries = entries + 1;

         // Redirect target uses EPC from before the edge
         redir_v_m = leave || enter;
         if (leave)
            redir_pc_m = epc_m;
         else if (enter)
            redir_pc_m = `EPU_IRQ_VECTOR;

         // EPC and EPSR before PSR, they need the old PSR
         if (enter)
            epc_m = retire_pc;
         else if (msr_we && msr_addr == `EPU_ADDR_EPC && !leave)
            epc_m = msr_wdat;
         if (enter)
            epsr_m = psr_m;
         else if (msr_we && msr_addr == `EPU_ADDR_EPSR && !leave)
            epsr_m = wr_psr;
         if (leave)
            psr_m = epsr_m;
         else if (enter)
            psr_m = 64'h2;
         else if (msr_we && msr_addr == `EPU_ADDR_PSR)
            psr_m = wr_psr;

         // IMR write lands even during a trap
         imr_m  = imr_eff;
         irr_m  = sync_m;
         sync_m = irqs;
      end
   end

endmodule

`default_nettype wire

/* verif/tb_epu.sv */
/*
 Testbench top for the EPU. Clock, reset, LFSR-driven random
 stimulus on the falling edge and a watchdog. Comparison lives in
 epu_checker, which watches the DUT ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "epu_config.svh"

module tb_epu;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   localparam int READ_CYCLES  = 5;
   localparam int RAND_CYCLES  = 3000;
   localparam int TAIL_CYCLES  = 3;

   logic                     clk = 1'b0;
   logic                     arst_n;
   logic [`EPU_NUM_IRQ-1:0]  irqs;
   logic                     retire_valid;
   logic [`EPU_DW-1:0]       retire_pc;
   logic                     retire_eret;
   logic                     msr_we;
   logic [`EPU_MSR_AW-1:0]   msr_addr;
   logic [`EPU_DW-1:0]       msr_wdat;
   logic [`EPU_DW-1:0]       msr_rdat;
   logic                     irq_req;
   logic                     redirect_valid;
   logic [`EPU_DW-1:0]       redirect_pc;
   logic [31:0]              mismatches;
   logic [31:0]              checks;
   logic [31:0]              entries;
   logic [31:0]              returns;
   logic [31:0]              lfsr_q;
   int                       other_errors;

   epu_top UUT (.*);

   epu_checker u_checker (.*);

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit
   task automatic draw(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[62:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic drive_random_cycle();
      logic [63:0] r;
      // Sparse IRQ toggles, one line about every fourth cycle
      draw(2, r);
      if (r[1:0] == 2'd0) begin
         draw(5, r);
         irqs[r[4:0] % `EPU_NUM_IRQ] = ~irqs[r[4:0] % `EPU_NUM_IRQ];
      end
      draw(1, r);
      retire_valid = r[0];
      draw(3, r);
      retire_eret = (r[2:0] == 3'd0);
      draw(62, r);
      retire_pc = {r[61:0], 2'b00};
      // About 1 in 6
      draw(8, r);
      msr_we = (r[7:0] < 8'd43);
      // Addresses 5 to 7 are unmapped
      draw(3, r);
      msr_addr = `EPU_MSR_AW'(r[2:0]);
      draw(64, r);
      msr_wdat = r;
   endtask

   task automatic drive_idle();
      retire_valid = 1'b0;
      retire_eret  = 1'b0;
      msr_we       = 1'b0;
   endtask

   // Watchdog
   initial begin
      #((RESET_CYCLES + READ_CYCLES + RAND_CYCLES + TAIL_CYCLES + 50) * CLK_PERIOD);
      $display("Timeout: the run did not reach its end in time");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      arst_n       = 1'b0;
      irqs         = '0;
      retire_valid = 1'b0;
      retire_pc    = '0;
      retire_eret  = 1'b0;
      msr_we       = 1'b0;
      msr_addr     = '0;
      msr_wdat     = '0;
      lfsr_q       = 32'h42adfedf;
      other_errors = 0;
      if (`EPU_NUM_IRQ > `EPU_DW) begin
         $display("Config error: EPU_NUM_IRQ is larger than EPU_DW");
         other_errors++;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      // Read every MSR once in its reset state
      for (int a = 0; a < READ_CYCLES; a++) begin
         msr_addr = `EPU_MSR_AW'(a);
         @(negedge clk);
      end
      repeat (RAND_CYCLES) begin
         drive_random_cycle();
         @(negedge clk);
      end
      // Let the last redirect pulse reach the checker
      drive_idle();
      repeat (TAIL_CYCLES) @(negedge clk);
      $display({"Summary: %0d cycles checked, %0d entries, %0d returns, ",
                "%0d mismatches, %0d other errors"},
               checks, entries, returns, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
